/* include/netWeights.svh */
`ifndef netWeightsSvh
`define netWeightsSvh

// ##################################################
// Hidden layer defaults
// Neuron 3 on the top line and input 7 leftmost on each line

`define hiddenWeightsDefault { \
	 24'sd5, -24'sd3,  24'sd7,  24'sd2, -24'sd6,  24'sd4,  24'sd1,  24'sd3, \
	-24'sd2,  24'sd6,  24'sd3, -24'sd4,  24'sd8,  24'sd1, -24'sd5,  24'sd2, \
	 24'sd4,  24'sd4, -24'sd7,  24'sd6,  24'sd2, -24'sd3,  24'sd5,  24'sd1, \
	 24'sd3, -24'sd1,  24'sd2,  24'sd5, -24'sd2,  24'sd7,  24'sd4,  24'sd6  \
	}

// Neuron 3 leftmost
`define hiddenBiasDefault {-24'sd40, 24'sd25, 24'sd12, 24'sd30}

// ##################################################
// Output layer defaults
// Class 2 on the top line and hidden neuron 3 leftmost

`define outWeightsDefault { \
	 24'sd9, -24'sd4,  24'sd6,  24'sd3, \
	-24'sd5,  24'sd8,  24'sd2,  24'sd7, \
	 24'sd6,  24'sd5, -24'sd3,  24'sd4  \
	}

`define outBiasDefault {24'sd16, -24'sd8, 24'sd20}

`endif

/* hw/fixedPkg.sv */
package fixedPkg;

	// ##################################################
	// Fixed-point number format of the network

	parameter int sumWidth = 24;    // Products, sums, weights and biases
	parameter int actWidth = 8;     // Activations and scores

	// Sums above this clamp to full scale
	parameter int satLimit = 4096;

	parameter int fracShift = 5;    // Activation is sum[fracShift+actWidth-1:fracShift]

	typedef logic signed [sumWidth-1:0] sumT;
	typedef logic [actWidth-1:0] actT;

endpackage

/* hw/ctrlPkg.sv */
package ctrlPkg;

	// ##################################################
	// Sequencing of one classification

	typedef enum logic [1:0]
	{
		idle,   // Waiting for req
		busy,   // Vector travelling through both layers
		done    // Result held, ack high until req drops
	} ctrlState;

	// Input register, sum register, activation register
	parameter int layerLatency = 3;

endpackage

/* hw/neuronNode.sv */
module neuronNode #(
	parameter int fanIn = 8,
	parameter fixedPkg::sumT [fanIn-1:0] weights = '0,
	parameter fixedPkg::sumT bias = '0
)(
	input logic clk,
	input logic reset,
	input fixedPkg::actT [fanIn-1:0] operands,
	output fixedPkg::actT activation
);

	fixedPkg::actT [fanIn-1:0] operandReg;
	fixedPkg::sumT total;
	fixedPkg::sumT sumReg;

	// ##################################################
	// Weighted sum

	// Only the low sumWidth bits of each product and of the total survive
	always_comb
	begin
		total = bias;
		for (int i = 0; i < fanIn; i++)
			total = total + fixedPkg::sumT'(operandReg[i]) * fixedPkg::sumT'(weights[i]);
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			operandReg <= '0;
			sumReg <= '0;
		end
		else
		begin
			operandReg <= operands;
			sumReg <= total;
		end
	end

	// ##################################################
	// Clamped activation

	always_ff @(posedge clk)
	begin
		if (reset)
			activation <= '0;
		else if (sumReg[fixedPkg::sumWidth-1])
			activation <= '0;   // Negative sum
		else if (sumReg > fixedPkg::satLimit)
			activation <= '1;   // Saturate
		else
			activation <= sumReg[fixedPkg::fracShift+fixedPkg::actWidth-1:fixedPkg::fracShift];
	end

	negClamp: assert property (
		@(posedge clk) disable iff (reset)
		sumReg[fixedPkg::sumWidth-1] |=> activation == '0
	);

endmodule

/* hw/neuralLayer.sv */
module neuralLayer #(
	parameter int fanIn = 8,
	parameter int numNodes = 4,
	parameter fixedPkg::sumT [numNodes*fanIn-1:0] weights = '0,
	parameter fixedPkg::sumT [numNodes-1:0] bias = '0
)(
	input logic clk,
	input logic reset,
	input fixedPkg::actT [fanIn-1:0] operands,
	output fixedPkg::actT [numNodes-1:0] activations
);

	// Row n of the weight table belongs to neuron n
	for (genvar n = 0; n < numNodes; n++)
	begin : nodes
		neuronNode #(
			.fanIn(fanIn),
			.weights(weights[n*fanIn +: fanIn]),
			.bias(bias[n])
		) node (
			.clk(clk),
			.reset(reset),
			.operands(operands),   // Every neuron sees the whole input vector
			.activation(activations[n])
		);
	end

endmodule

/* hw/argMax.sv */
module argMax #(
	parameter int numClasses = 3,
	localparam int indexWidth = (numClasses > 1) ? $clog2(numClasses) : 1
)(
	input logic clk,
	input logic reset,
	input logic capture,
	input fixedPkg::actT [numClasses-1:0] candidates,
	output fixedPkg::actT [numClasses-1:0] scores,
	output logic [indexWidth-1:0] classIndex
);

	fixedPkg::actT bestScore;
	logic [indexWidth-1:0] bestIndex;

	// Strictly greater, so the first of equal scores is kept
	always_comb
	begin
		bestScore = candidates[0];
		bestIndex = '0;
		for (int i = 1; i < numClasses; i++)
		begin
			if (candidates[i] > bestScore)
			begin
				bestScore = candidates[i];
				bestIndex = indexWidth'(i);
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			scores <= '0;
			classIndex <= '0;
		end
		else if (capture)
		begin
			scores <= candidates;
			classIndex <= bestIndex;
		end
	end

	indexRange: assert property (
		@(posedge clk) disable iff (reset)
		classIndex < numClasses
	);

endmodule

/* hw/classifyCtrl.sv */
module classifyCtrl #(
	parameter int pipeDepth = 6,
	localparam int countWidth = $clog2(pipeDepth + 1)
)(
	input logic clk,
	input logic reset,
	input logic req,
	output logic ack,
	output logic capture
);

	ctrlPkg::ctrlState state;
	logic [countWidth-1:0] waitCount;

	// ##################################################
	// Four-phase handshake

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= ctrlPkg::idle;
			waitCount <= '0;
			capture <= 1'b0;
			ack <= 1'b0;
		end
		else
		begin
			capture <= 1'b0;
			case (state)
				ctrlPkg::idle:
				begin
					if (req)
					begin
						state <= ctrlPkg::busy;
						waitCount <= '0;
					end
				end
				ctrlPkg::busy:
				begin
					// Last wait cycle strobes the capture
					if (waitCount == countWidth'(pipeDepth - 1))
					begin
						capture <= 1'b1;
						state <= ctrlPkg::done;
					end
					else
						waitCount <= waitCount + 1'b1;
				end
				ctrlPkg::done:
				begin
					if (capture)
						ack <= 1'b1;   // Result registered at this edge
					else if (ack && !req)
					begin
						ack <= 1'b0;
						state <= ctrlPkg::idle;
					end
				end
				default:
					state <= ctrlPkg::idle;
			endcase
		end
	end

	ackNeedsReq: assert property (
		@(posedge clk) disable iff (reset)
		$rose(ack) |-> $past(req)
	);

	// One strobe per request
	capturePulse: assert property (
		@(posedge clk) disable iff (reset)
		capture |=> !capture
	);

endmodule

/* hw/netTop.sv */
`include "netWeights.svh"

module netTop #(
	parameter int numInputs = 8,
	parameter int numHidden = 4,
	parameter int numClasses = 3,
	parameter fixedPkg::sumT [numHidden*numInputs-1:0] hiddenWeights = `hiddenWeightsDefault,
	parameter fixedPkg::sumT [numHidden-1:0] hiddenBias = `hiddenBiasDefault,
	parameter fixedPkg::sumT [numClasses*numHidden-1:0] outWeights = `outWeightsDefault,
	parameter fixedPkg::sumT [numClasses-1:0] outBias = `outBiasDefault,
	localparam int indexWidth = (numClasses > 1) ? $clog2(numClasses) : 1
)(
	input logic clk,
	input logic reset,
	input logic req,
	input fixedPkg::actT [numInputs-1:0] features,
	output logic ack,
	output fixedPkg::actT [numClasses-1:0] scores,
	output logic [indexWidth-1:0] classIndex
);

	fixedPkg::actT [numHidden-1:0] hiddenActs;
	fixedPkg::actT [numClasses-1:0] outActs;
	logic capture;

	// ##################################################
	// Data path

	neuralLayer #(
		.fanIn(numInputs),
		.numNodes(numHidden),
		.weights(hiddenWeights),
		.bias(hiddenBias)
	) hiddenLayer (
		.clk(clk),
		.reset(reset),
		.operands(features),
		.activations(hiddenActs)
	);

	neuralLayer #(
		.fanIn(numHidden),
		.numNodes(numClasses),
		.weights(outWeights),
		.bias(outBias)
	) outputLayer (
		.clk(clk),
		.reset(reset),
		.operands(hiddenActs),
		.activations(outActs)
	);

	argMax #(.numClasses(numClasses)) picker (
		.clk(clk),
		.reset(reset),
		.capture(capture),
		.candidates(outActs),
		.scores(scores),
		.classIndex(classIndex)
	);

	// Waits out both layers before the capture
	classifyCtrl #(.pipeDepth(2 * ctrlPkg::layerLatency)) sequencer (
		.clk(clk),
		.reset(reset),
		.req(req),
		.ack(ack),
		.capture(capture)
	);

endmodule

/* bench/netTopTb.sv */
module netTopTb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int numInputs = 8;
	localparam int numClasses = 3;
	localparam int maxTests = 32;
	localparam int ackWaitLimit = 20;   // Pipeline needs 7 edges

	logic clk;
	logic reset;
	logic req;
	fixedPkg::actT [numInputs-1:0] features;
	logic ack;
	fixedPkg::actT [numClasses-1:0] scores;
	logic [1:0] classIndex;

	string testName [maxTests];
	int traceIn [maxTests][numInputs];
	int traceScore [maxTests][numClasses];
	int traceClass [maxTests];
	int numTests = 0;

	int errorCount = 0;
	int checkCount = 0;
	int cycleCount = 0;
	int cycleLimit = 0;
	integer seed = 32'h8499;
	logic prevAck = 1'b0;

	netTop dut (
		.clk(clk),
		.reset(reset),
		.req(req),
		.features(features),
		.ack(ack),
		.scores(scores),
		.classIndex(classIndex)
	);

	always #50 clk = ~clk;

	// ##################################################
	// Helpers

	task automatic stepCycle();
		@(posedge clk);
		#1;   // Sample and drive point
	endtask

	task automatic checkValue(string testId, string what, int expected, int actual);
		checkCount++;
		assert (actual == expected)
		else
		begin
			$display("Mismatch %s %s: expected %0d, actual %0d", testId, what, expected, actual);
			errorCount++;
		end
	endtask

	task automatic checkResult(int t, string tag);
		for (int c = 0; c < numClasses; c++)
			checkValue(testName[t], $sformatf("%s score%0d", tag, c), traceScore[t][c],
				int'(scores[c]));
		checkValue(testName[t], {tag, " class"}, traceClass[t], int'(classIndex));
	endtask

	task automatic readTrace();
		int fd;
		int fields;
		string line;
		fd = $fopen("bench/netTrace.txt", "r");
		if (fd == 0)
		begin
			$display("Could not open the trace file bench/netTrace.txt");
			errorCount++;
			return;
		end
		while ($fgets(line, fd) > 0 && numTests < maxTests)
		begin
			if (line.len() < 2 || line.getc(0) == "#")
				continue;   // Column notes
			fields = $sscanf(line, "%s %d %d %d %d %d %d %d %d %d %d %d %d", testName[numTests],
				traceIn[numTests][0], traceIn[numTests][1], traceIn[numTests][2],
				traceIn[numTests][3], traceIn[numTests][4], traceIn[numTests][5],
				traceIn[numTests][6], traceIn[numTests][7], traceScore[numTests][0],
				traceScore[numTests][1], traceScore[numTests][2], traceClass[numTests]);
			if (fields == 13)
				numTests++;
			else
			begin
				$display("Trace line could not be read: %s", line);
				errorCount++;
			end
		end
		$fclose(fd);
	endtask

	task automatic waitForAck(logic level, string testId, output logic seen);
		seen = 1'b0;
		for (int i = 0; i < ackWaitLimit && !seen; i++)
		begin
			stepCycle();
			seen = (ack == level);
		end
		assert (seen)
		else
		begin
			$display("%s: ack did not go to %0d within %0d cycles", testId, level, ackWaitLimit);
			errorCount++;
		end
	endtask

	// ##################################################
	// One classification

	task automatic runTest(int t);
		logic seen;
		for (int i = 0; i < numInputs; i++)
			features[i] = fixedPkg::actT'(traceIn[t][i]);
		req = 1'b1;
		waitForAck(1'b1, testName[t], seen);
		if (seen)
		begin
			checkResult(t, "ack");
			for (int i = 0; i < numInputs; i++)
				features[i] = fixedPkg::actT'($random(seed));   // Result must not follow
			repeat (2) stepCycle();
			checkValue(testName[t], "ack held", 1, int'(ack));
			checkResult(t, "held");
		end
		req = 1'b0;
		waitForAck(1'b0, testName[t], seen);
		repeat (3)
		begin
			stepCycle();
			checkValue(testName[t], "idle ack", 0, int'(ack));
		end
	endtask

	task automatic endRun();
		$display("Checks: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	endtask

	// ##################################################
	// Handshake order, sampled mid cycle

	always @(negedge clk)
	begin
		if (!reset)
		begin
			assert (!(ack && !prevAck && !req))
			else
			begin
				$display("The ack signal rose while req was low");
				errorCount++;
			end
			assert (!(!ack && prevAck && req))
			else
			begin
				$display("The ack signal fell while req was still high");
				errorCount++;
			end
		end
		prevAck = ack;
	end

	initial
	begin
		wait (cycleLimit > 0);
		while (cycleCount < cycleLimit)
		begin
			@(posedge clk);
			cycleCount++;
		end
		$display("Timeout: the run did not finish within %0d cycles", cycleLimit);
		errorCount++;
		endRun();
	end

	initial
	begin
		clk = 1'b0;
		reset = 1'b1;
		req = 1'b0;
		features = '0;
		readTrace();
		assert (numTests > 0)
		else
		begin
			$display("The trace holds no test lines");
			errorCount++;
		end
		cycleLimit = numTests * 20 + 50;
		repeat (8) @(posedge clk);
		#1;
		reset = 1'b0;
		stepCycle();
		checkValue("afterReset", "ack", 0, int'(ack));   // Nothing captured yet
		checkValue("afterReset", "class", 0, int'(classIndex));
		for (int c = 0; c < numClasses; c++)
			checkValue("afterReset", $sformatf("score%0d", c), 0, int'(scores[c]));
		for (int t = 0; t < numTests; t++)
			runTest(t);
		endRun();
	end

endmodule

/* bench/netTrace.txt */
# name x0 x1 x2 x3 x4 x5 x6 x7 score0 score1 score2 class
# Inputs and scores in decimal, class is the winning index
zeroTie 0 0 0 0 0 0 0 0 0 0 0 0
allMax 255 255 255 255 255 255 255 255 53 63 62 1
ramp 10 20 30 40 50 60 70 80 8 7 9 2
hiddenSat 0 255 255 0 0 255 0 255 80 15 96 2
negSum 0 0 0 0 0 255 0 255 24 0 29 2
onlyX3 0 0 0 255 0 0 0 0 9 16 0 1
onlyX0 255 0 0 0 0 0 0 0 12 11 10 0
onlyX4 0 0 0 0 255 0 0 0 3 9 17 2
onlyX6 0 0 0 0 0 0 255 0 5 13 0 1
tieTop 20 40 60 105 100 120 140 160 15 17 17 1
rampAgain 10 20 30 40 50 60 70 80 8 7 9 2

/* netTop.f */
+incdir+include
hw/fixedPkg.sv
hw/ctrlPkg.sv
hw/neuronNode.sv
hw/neuralLayer.sv
hw/argMax.sv
hw/classifyCtrl.sv
hw/netTop.sv
bench/netTopTb.sv

/* run.sh */
#!/bin/sh
# Builds and runs the netTop testbench with Verilator

cd "$(dirname "$0")" || exit 1

logFile=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
	-f netTop.f --top-module netTopTb -o netTopSim
if [ $? -ne 0 ]
then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/netTopSim > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]
then
	echo "Simulation exited with status $simStatus"
	exit 1
fi

if grep -q "Test failed" "$logFile"
then
	exit 1
fi
exit 0
